// File: source/fp_alu_cfg.svh
`ifndef FP_ALU_CFG_SVH
`define FP_ALU_CFG_SVH

// width of an operand or result word.
`define FP_WIDTH 32

// biased exponent field.
`define FP_EXP_WIDTH 8

// stored fraction, without the hidden one.
`define FP_FRAC_WIDTH 23

// working mantissa with a carry bit, the hidden one and the fraction.
`define FP_MANT_WIDTH 25

`define FP_EXP_BIAS 127

// the opcode field holds the five-bit operation encoding.
`define FP_OP_WIDTH 5

`endif

// File: source/fp_format_pkg.sv
`include "fp_alu_cfg.svh"

package fp_format_pkg;

    // a packed single-precision word with sign, exponent and fraction.
    typedef logic [`FP_WIDTH-1:0] fp_word_t;

    // the exponent is kept in its biased form throughout the datapath.
    typedef logic [`FP_EXP_WIDTH-1:0] fp_exp_t;

    typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;

    // bit 24 catches the carry of an addition and bit 23 holds the hidden one.
    // The remaining bits are the stored fraction.
    typedef logic [`FP_MANT_WIDTH-1:0] fp_mant_t;

endpackage

// File: source/fp_alu_op_pkg.sv
`include "fp_alu_cfg.svh"

package fp_alu_op_pkg;

    // codes 19 to 21 are reserved and behave like NOP.
    typedef enum logic [`FP_OP_WIDTH-1:0] {
        OP_ADD    = 5'd16,
        OP_SUB    = 5'd17,
        OP_MUL    = 5'd18,
        OP_RSV_19 = 5'd19,
        OP_RSV_20 = 5'd20,
        OP_RSV_21 = 5'd21,
        OP_NOP    = 5'd22,
        OP_SLT    = 5'd23
    } alu_op_e;

    // source of the word that the second stage registers.
    typedef enum logic [1:0] {
        SEL_BYPASS = 2'd0,
        SEL_ADDSUB = 2'd1,
        SEL_MUL    = 2'd2,
        SEL_SLT    = 2'd3
    } result_sel_e;

endpackage

// File: source/fp_operand_stage.sv
`timescale 1ns/1ps
`include "fp_alu_cfg.svh"

module fp_operand_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  fp_format_pkg::fp_word_t    input1,
    input  fp_format_pkg::fp_word_t    input2,
    input  fp_alu_op_pkg::alu_op_e     operation,
    input  logic                       op_valid,
    output logic                       s1_valid,
    output fp_alu_op_pkg::result_sel_e s1_sel,
    output fp_format_pkg::fp_word_t    s1_bypass,
    output logic                       s1_sign1,
    output logic                       s1_sign2,
    output fp_format_pkg::fp_exp_t     s1_exp,
    output fp_format_pkg::fp_mant_t    s1_mant1,
    output fp_format_pkg::fp_mant_t    s1_mant2,
    output logic                       s1_effective_sub,
    output fp_format_pkg::fp_exp_t     s1_exp1,
    output fp_format_pkg::fp_exp_t     s1_exp2,
    output fp_format_pkg::fp_mant_t    s1_mant1_raw,
    output fp_format_pkg::fp_mant_t    s1_mant2_raw
);
    import fp_format_pkg::*;
    import fp_alu_op_pkg::*;

    logic        sign1;
    logic        sign2;
    fp_exp_t     exp1;
    fp_exp_t     exp2;
    fp_mant_t    mant1_raw;
    fp_mant_t    mant2_raw;
    logic        zero1;
    logic        zero2;
    logic        exp1_ge;
    fp_exp_t     exp_diff;
    fp_exp_t     align_exp;
    fp_mant_t    align_mant1;
    fp_mant_t    align_mant2;
    logic        effective_sub;
    result_sel_e sel;
    fp_word_t    bypass;

    assign sign1 = input1[`FP_WIDTH-1];
    assign sign2 = input2[`FP_WIDTH-1];
    assign exp1  = input1[`FP_WIDTH-2:`FP_FRAC_WIDTH];
    assign exp2  = input2[`FP_WIDTH-2:`FP_FRAC_WIDTH];

    // the hidden one is restored for every operand, zero included.
    assign mant1_raw = {1'b0, 1'b1, input1[`FP_FRAC_WIDTH-1:0]};
    assign mant2_raw = {1'b0, 1'b1, input2[`FP_FRAC_WIDTH-1:0]};

    // a zero of either sign has an all-zero magnitude.
    assign zero1 = (input1[`FP_WIDTH-2:0] == '0);
    assign zero2 = (input2[`FP_WIDTH-2:0] == '0);

    // the smaller operand is shifted right and its low bits are simply lost.
    assign exp1_ge     = (exp1 >= exp2);
    assign exp_diff    = exp1_ge ? exp1 - exp2 : exp2 - exp1;
    assign align_exp   = exp1_ge ? exp1 : exp2;
    assign align_mant1 = exp1_ge ? mant1_raw : mant1_raw >> exp_diff;
    assign align_mant2 = exp1_ge ? mant2_raw >> exp_diff : mant2_raw;

    assign effective_sub = sign1 ^ sign2 ^ (operation == OP_SUB);

    always_comb begin
        sel    = SEL_BYPASS;
        bypass = input1;
        case (operation)
            OP_ADD, OP_SUB: begin
                if (zero2) begin
                    bypass = input1;
                end else if (zero1) begin
                    // 0 - x is -x, so SUB flips the sign of input2.
                    bypass = (operation == OP_SUB) ?
                             {~sign2, input2[`FP_WIDTH-2:0]} : input2;
                end else begin
                    sel = SEL_ADDSUB;
                end
            end
            OP_MUL: begin
                if (zero1 || zero2) begin
                    bypass = '0;
                end else begin
                    sel = SEL_MUL;
                end
            end
            OP_SLT: sel = SEL_SLT;
            // NOP and the reserved codes pass input1 through.
            default: sel = SEL_BYPASS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_sel           <= sel;
        s1_bypass        <= bypass;
        s1_sign1         <= sign1;
        s1_sign2         <= sign2;
        s1_exp           <= align_exp;
        s1_mant1         <= align_mant1;
        s1_mant2         <= align_mant2;
        s1_effective_sub <= effective_sub;
        s1_exp1          <= exp1;
        s1_exp2          <= exp2;
        s1_mant1_raw     <= mant1_raw;
        s1_mant2_raw     <= mant2_raw;
    end

endmodule

// File: source/fp_addsub.sv
`timescale 1ns/1ps
`include "fp_alu_cfg.svh"

module fp_addsub (
    input  logic                    s1_sign1,
    input  logic                    s1_sign2,
    input  logic                    s1_effective_sub,
    input  fp_format_pkg::fp_exp_t  s1_exp,
    input  fp_format_pkg::fp_mant_t s1_mant1,
    input  fp_format_pkg::fp_mant_t s1_mant2,
    output fp_format_pkg::fp_word_t sum_word
);
    import fp_format_pkg::*;

    logic     is_sub;
    logic     op2_sign;
    fp_mant_t add_mant;
    fp_mant_t add_norm;
    fp_exp_t  add_exp;
    logic     mant1_larger;
    fp_mant_t diff_mant;
    logic     diff_sign;
    fp_exp_t  lead_shift;
    fp_mant_t sub_norm;
    fp_exp_t  sub_exp;

    // the opcode is recovered from the signs and the effective operation.
    assign is_sub   = s1_effective_sub ^ s1_sign1 ^ s1_sign2;
    assign op2_sign = s1_sign2 ^ is_sub;

    // both mantissas are below two, so one right shift absorbs any carry.
    assign add_mant = s1_mant1 + s1_mant2;
    assign add_norm = add_mant[`FP_MANT_WIDTH-1] ? add_mant >> 1 : add_mant;
    assign add_exp  = s1_exp + fp_exp_t'(add_mant[`FP_MANT_WIDTH-1]);

    assign mant1_larger = (s1_mant1 >= s1_mant2);
    assign diff_mant    = mant1_larger ? s1_mant1 - s1_mant2 : s1_mant2 - s1_mant1;
    assign diff_sign    = mant1_larger ? s1_sign1 : op2_sign;

    // the highest set bit wins, giving its distance below the hidden-one position.
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < `FP_MANT_WIDTH - 1; i++) begin
            if (diff_mant[i]) begin
                lead_shift = fp_exp_t'(`FP_MANT_WIDTH - 2 - i);
            end
        end
    end

    assign sub_norm = diff_mant << lead_shift;
    assign sub_exp  = s1_exp - lead_shift;

    always_comb begin
        if (!s1_effective_sub) begin
            sum_word = {s1_sign1, add_exp, add_norm[`FP_FRAC_WIDTH-1:0]};
        end else if (diff_mant == '0) begin
            // exact cancellation always gives positive zero.
            sum_word = '0;
        end else begin
            sum_word = {diff_sign, sub_exp, sub_norm[`FP_FRAC_WIDTH-1:0]};
        end
    end

endmodule

// File: source/fp_mul.sv
`timescale 1ns/1ps
`include "fp_alu_cfg.svh"

module fp_mul (
    input  logic                    s1_sign1,
    input  logic                    s1_sign2,
    input  fp_format_pkg::fp_exp_t  s1_exp1,
    input  fp_format_pkg::fp_exp_t  s1_exp2,
    input  fp_format_pkg::fp_mant_t s1_mant1_raw,
    input  fp_format_pkg::fp_mant_t s1_mant2_raw,
    output fp_format_pkg::fp_word_t product_word
);
    import fp_format_pkg::*;

    localparam int PROD_WIDTH = 2 * (`FP_MANT_WIDTH - 1);

    logic [PROD_WIDTH-1:0] product;
    logic                  prod_ge_two;
    fp_mant_t              prod_top;
    fp_mant_t              prod_norm;
    fp_exp_t               prod_exp;

    // only the 24 significant bits take part since the carry bit is always clear.
    assign product = s1_mant1_raw[`FP_MANT_WIDTH-2:0] * s1_mant2_raw[`FP_MANT_WIDTH-2:0];

    assign prod_ge_two = product[PROD_WIDTH-1];
    assign prod_top    = product[PROD_WIDTH-1:PROD_WIDTH-`FP_MANT_WIDTH];

    // a product below two is moved up so its leading one sits in the carry bit.
    assign prod_norm = prod_ge_two ? prod_top : prod_top << 1;

    // the exponent wraps on overflow.
    assign prod_exp = s1_exp1 + s1_exp2 - fp_exp_t'(`FP_EXP_BIAS)
                      + fp_exp_t'(prod_ge_two);

    assign product_word = {s1_sign1 ^ s1_sign2, prod_exp, prod_norm[`FP_FRAC_WIDTH:1]};

endmodule

// File: source/fp_less_than.sv
`timescale 1ns/1ps

module fp_less_than (
    input  logic                    s1_sign1,
    input  logic                    s1_sign2,
    input  fp_format_pkg::fp_exp_t  s1_exp1,
    input  fp_format_pkg::fp_exp_t  s1_exp2,
    input  fp_format_pkg::fp_mant_t s1_mant1_raw,
    input  fp_format_pkg::fp_mant_t s1_mant2_raw,
    output fp_format_pkg::fp_word_t less_word
);
    import fp_format_pkg::*;

    logic mag_less;
    logic mag_greater;
    logic is_less;

    assign mag_less    = (s1_exp1 < s1_exp2) ||
                         ((s1_exp1 == s1_exp2) && (s1_mant1_raw < s1_mant2_raw));
    assign mag_greater = (s1_exp1 > s1_exp2) ||
                         ((s1_exp1 == s1_exp2) && (s1_mant1_raw > s1_mant2_raw));

    // a negative operand is below a positive one, so -0 < +0 holds too.
    always_comb begin
        if (s1_sign1 != s1_sign2) begin
            is_less = s1_sign1;
        end else if (!s1_sign1) begin
            is_less = mag_less;
        end else begin
            // for two negatives the larger magnitude is the smaller number.
            is_less = mag_greater;
        end
    end

    assign less_word = fp_word_t'(is_less);

endmodule

// File: source/fp_result_stage.sv
`timescale 1ns/1ps

module fp_result_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s1_valid,
    input  fp_alu_op_pkg::result_sel_e s1_sel,
    input  fp_format_pkg::fp_word_t    s1_bypass,
    input  fp_format_pkg::fp_word_t    sum_word,
    input  fp_format_pkg::fp_word_t    product_word,
    input  fp_format_pkg::fp_word_t    less_word,
    output fp_format_pkg::fp_word_t    result,
    output logic                       result_valid
);
    import fp_format_pkg::*;
    import fp_alu_op_pkg::*;

    fp_word_t selected;

    always_comb begin
        case (s1_sel)
            SEL_ADDSUB: selected = sum_word;
            SEL_MUL:    selected = product_word;
            SEL_SLT:    selected = less_word;
            default:    selected = s1_bypass;
        endcase
    end

    // the word loads every cycle and is qualified by result_valid.
    always_ff @(posedge clk) begin
        if (reset) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            result       <= selected;
            result_valid <= s1_valid;
        end
    end

endmodule

// File: source/fp_alu.sv
`timescale 1ns/1ps

module fp_alu (
    input  logic                    clk,
    input  logic                    reset,
    input  fp_format_pkg::fp_word_t input1,
    input  fp_format_pkg::fp_word_t input2,
    input  fp_alu_op_pkg::alu_op_e  operation,
    input  logic                    op_valid,
    output fp_format_pkg::fp_word_t result,
    output logic                    result_valid
);
    import fp_format_pkg::*;
    import fp_alu_op_pkg::*;

    logic        s1_valid;
    result_sel_e s1_sel;
    fp_word_t    s1_bypass;
    logic        s1_sign1;
    logic        s1_sign2;
    fp_exp_t     s1_exp;
    fp_mant_t    s1_mant1;
    fp_mant_t    s1_mant2;
    logic        s1_effective_sub;
    fp_exp_t     s1_exp1;
    fp_exp_t     s1_exp2;
    fp_mant_t    s1_mant1_raw;
    fp_mant_t    s1_mant2_raw;
    fp_word_t    sum_word;
    fp_word_t    product_word;
    fp_word_t    less_word;

    fp_operand_stage u_operand_stage (
        .clk              (clk),
        .reset            (reset),
        .input1           (input1),
        .input2           (input2),
        .operation        (operation),
        .op_valid         (op_valid),
        .s1_valid         (s1_valid),
        .s1_sel           (s1_sel),
        .s1_bypass        (s1_bypass),
        .s1_sign1         (s1_sign1),
        .s1_sign2         (s1_sign2),
        .s1_exp           (s1_exp),
        .s1_mant1         (s1_mant1),
        .s1_mant2         (s1_mant2),
        .s1_effective_sub (s1_effective_sub),
        .s1_exp1          (s1_exp1),
        .s1_exp2          (s1_exp2),
        .s1_mant1_raw     (s1_mant1_raw),
        .s1_mant2_raw     (s1_mant2_raw)
    );

    // the three units are combinational and all read the same stage-1 registers.
    fp_addsub u_addsub (
        .s1_sign1         (s1_sign1),
        .s1_sign2         (s1_sign2),
        .s1_effective_sub (s1_effective_sub),
        .s1_exp           (s1_exp),
        .s1_mant1         (s1_mant1),
        .s1_mant2         (s1_mant2),
        .sum_word         (sum_word)
    );

    fp_mul u_mul (
        .s1_sign1     (s1_sign1),
        .s1_sign2     (s1_sign2),
        .s1_exp1      (s1_exp1),
        .s1_exp2      (s1_exp2),
        .s1_mant1_raw (s1_mant1_raw),
        .s1_mant2_raw (s1_mant2_raw),
        .product_word (product_word)
    );

    fp_less_than u_less_than (
        .s1_sign1     (s1_sign1),
        .s1_sign2     (s1_sign2),
        .s1_exp1      (s1_exp1),
        .s1_exp2      (s1_exp2),
        .s1_mant1_raw (s1_mant1_raw),
        .s1_mant2_raw (s1_mant2_raw),
        .less_word    (less_word)
    );

    fp_result_stage u_result_stage (
        .clk          (clk),
        .reset        (reset),
        .s1_valid     (s1_valid),
        .s1_sel       (s1_sel),
        .s1_bypass    (s1_bypass),
        .sum_word     (sum_word),
        .product_word (product_word),
        .less_word    (less_word),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// File: testbench/fp_alu_vectors.svh
`ifndef FP_ALU_VECTORS_SVH
`define FP_ALU_VECTORS_SVH

// each entry gives the operation, input1, input2 and the expected result.
// All values are single-precision words in hex.
task automatic load_vectors;
    // add with equal signs, with and without a carry out of the mantissa.
    add_vector(OP_ADD,    32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000);
    add_vector(OP_ADD,    32'h3fc0_0000, 32'h3fc0_0000, 32'h4040_0000);
    // 3.0 + -1.0 and an exact cancellation to positive zero.
    add_vector(OP_ADD,    32'h4040_0000, 32'hbf80_0000, 32'h4000_0000);
    add_vector(OP_ADD,    32'h4000_0000, 32'hc000_0000, 32'h0000_0000);
    // a zero operand hands back the other one untouched.
    add_vector(OP_ADD,    32'h4040_0000, 32'h0000_0000, 32'h4040_0000);
    add_vector(OP_ADD,    32'h0000_0000, 32'hbfc0_0000, 32'hbfc0_0000);
    // 2^-30 is shifted out completely during alignment.
    add_vector(OP_ADD,    32'h3f80_0000, 32'h3080_0000, 32'h3f80_0000);
    // 5.0 - 1.5, 1.0 - 4.0, 0 - 2.5 and 5.0 - 0.
    add_vector(OP_SUB,    32'h40a0_0000, 32'h3fc0_0000, 32'h4060_0000);
    add_vector(OP_SUB,    32'h3f80_0000, 32'h4080_0000, 32'hc040_0000);
    add_vector(OP_SUB,    32'h0000_0000, 32'h4020_0000, 32'hc020_0000);
    add_vector(OP_SUB,    32'h40a0_0000, 32'h0000_0000, 32'h40a0_0000);
    // 1.5 * 2.0, then -1.5 * 1.5 which lands above two.
    add_vector(OP_MUL,    32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000);
    add_vector(OP_MUL,    32'hbfc0_0000, 32'h3fc0_0000, 32'hc010_0000);
    // a zero factor always gives positive zero.
    add_vector(OP_MUL,    32'h4040_0000, 32'h0000_0000, 32'h0000_0000);
    add_vector(OP_MUL,    32'hc000_0000, 32'h0000_0000, 32'h0000_0000);
    // less-than of -1 and 2, 2 and 1, -4 and -2, and 3 and 3.
    add_vector(OP_SLT,    32'hbf80_0000, 32'h4000_0000, 32'h0000_0001);
    add_vector(OP_SLT,    32'h4000_0000, 32'h3f80_0000, 32'h0000_0000);
    add_vector(OP_SLT,    32'hc080_0000, 32'hc000_0000, 32'h0000_0001);
    add_vector(OP_SLT,    32'h4040_0000, 32'h4040_0000, 32'h0000_0000);
    // negative zero orders below positive zero.
    add_vector(OP_SLT,    32'h8000_0000, 32'h0000_0000, 32'h0000_0001);
    add_vector(OP_SLT,    32'h0000_0000, 32'h8000_0000, 32'h0000_0000);
    // NOP and the reserved codes pass input1 through.
    add_vector(OP_NOP,    32'h4049_0fdb, 32'hc120_0000, 32'h4049_0fdb);
    add_vector(OP_RSV_19, 32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000);
    add_vector(OP_RSV_20, 32'hbf40_0000, 32'h0000_0000, 32'hbf40_0000);
    add_vector(OP_RSV_21, 32'hc2f6_0000, 32'h42c8_0000, 32'hc2f6_0000);
endtask

`endif

// File: testbench/fp_alu_tb.sv
`timescale 1ns/1ps

module fp_alu_tb;
    import fp_format_pkg::*;
    import fp_alu_op_pkg::*;

    typedef struct packed {
        alu_op_e  op;
        fp_word_t in1;
        fp_word_t in2;
        fp_word_t expected;
    } vector_t;

    logic     clk;
    logic     reset;
    fp_word_t input1;
    fp_word_t input2;
    alu_op_e  operation;
    logic     op_valid;
    fp_word_t result;
    logic     result_valid;

    vector_t  vectors[$];
    fp_word_t expected_q[$];
    int       due_q[$];
    int       index_q[$];
    int       cycle_count = 0;
    int       pass_count;
    int       fail_count;
    logic     timed_out;

    fp_alu u_dut (
        .clk          (clk),
        .reset        (reset),
        .input1       (input1),
        .input2       (input2),
        .operation    (operation),
        .op_valid     (op_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    task automatic add_vector(input alu_op_e op, input fp_word_t in1, input fp_word_t in2,
                              input fp_word_t expected);
        vector_t v;
        v.op       = op;
        v.in1      = in1;
        v.in2      = in2;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    `include "fp_alu_vectors.svh"

    task automatic check_idle_outputs(output logic ok);
        ok = 1'b1;
        if (result_valid !== 1'b0) begin
            $display("Fail reset: result_valid expected %h, got %h", 1'b0, result_valid);
            ok = 1'b0;
        end
        if (result !== 32'h0) begin
            $display("Fail reset: result expected %08h, got %08h", 32'h0, result);
            ok = 1'b0;
        end
    endtask

    // pops the oldest outstanding entry and checks its timing and value.
    task automatic compare_result;
        int       idx;
        int       due;
        fp_word_t want;
        idx  = index_q.pop_front();
        due  = due_q.pop_front();
        want = expected_q.pop_front();
        if (due != cycle_count) begin
            $display("test %0d failed: result came at cycle %0d instead of cycle %0d",
                     idx, cycle_count, due);
            fail_count++;
        end else if (result !== want) begin
            $display("Fail test %0d: result expected %08h, got %08h", idx, want, result);
            fail_count++;
        end else begin
            $display("test %0d passed, result %08h", idx, result);
            pass_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // each falling edge matches a valid result against the oldest outstanding entry.
    always @(negedge clk) begin
        if (result_valid) begin
            if (expected_q.size() == 0) begin
                $display("result_valid was high at cycle %0d with no operation outstanding",
                         cycle_count);
                fail_count++;
            end else begin
                compare_result();
            end
        end else if (due_q.size() > 0 && due_q[0] <= cycle_count) begin
            $display("test %0d failed: result_valid stayed low at cycle %0d",
                     index_q[0], cycle_count);
            fail_count++;
            void'(index_q.pop_front());
            void'(due_q.pop_front());
            void'(expected_q.pop_front());
        end
    end

    initial begin
        int   i;
        int   wait_cycles;
        logic idle_ok;
        logic reset_ok;

        reset      = 1'b1;
        op_valid   = 1'b0;
        input1     = '0;
        input2     = '0;
        operation  = OP_NOP;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        reset_ok   = 1'b1;
        load_vectors();

        // the outputs must stay idle on every cycle of the reset.
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            #2;
            check_idle_outputs(idle_ok);
            if (!idle_ok) begin
                reset_ok = 1'b0;
            end
        end
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #2;
            check_idle_outputs(idle_ok);
            if (!idle_ok) begin
                reset_ok = 1'b0;
            end
        end
        if (reset_ok) begin
            $display("reset test passed");
            pass_count++;
        end else begin
            $display("reset test failed: outputs were not idle during or after reset");
            fail_count++;
        end

        // one entry per cycle, so two operations are in flight at any time.
        for (i = 0; i < vectors.size(); i++) begin
            @(posedge clk);
            #2;
            op_valid  = 1'b1;
            operation = vectors[i].op;
            input1    = vectors[i].in1;
            input2    = vectors[i].in2;
            expected_q.push_back(vectors[i].expected);
            due_q.push_back(cycle_count + 2);
            index_q.push_back(i);
        end
        @(posedge clk);
        #2;
        op_valid = 1'b0;

        wait_cycles = 0;
        while (expected_q.size() > 0 && wait_cycles < 10) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (expected_q.size() > 0) begin
            $display("timeout: %0d results never arrived", expected_q.size());
            timed_out = 1'b1;
        end

        // a few idle cycles catch a stray result_valid.
        repeat (3) @(posedge clk);
        #2;
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
+incdir+testbench
source/fp_format_pkg.sv
source/fp_alu_op_pkg.sv
source/fp_operand_stage.sv
source/fp_addsub.sv
source/fp_mul.sv
source/fp_less_than.sv
source/fp_result_stage.sv
source/fp_alu.sv
testbench/fp_alu_tb.sv
